// File: cpu_defs_pkg.sv
package cpu_defs_pkg;

    // machine widths
    localparam int reg_w       = 32;  // data word
    localparam int dreg_w      = 64;  // {hi,lo}, products, divider result
    localparam int reg_addr_w  = 5;   // destination register address
    localparam int inst_addr_w = 32;  // link address
    localparam int alusel_w    = 3;

    // result class picks which unit drives alu_res
    localparam logic [alusel_w-1:0] res_nop         = 3'd0;
    localparam logic [alusel_w-1:0] res_logic       = 3'd1;
    localparam logic [alusel_w-1:0] res_shift       = 3'd2;
    localparam logic [alusel_w-1:0] res_move        = 3'd3;
    localparam logic [alusel_w-1:0] res_arith       = 3'd4;
    localparam logic [alusel_w-1:0] res_jump_branch = 3'd5;  // link address
    localparam logic [alusel_w-1:0] res_load_store  = 3'd6;  // effective address

endpackage

// File: alu_op_pkg.sv
package alu_op_pkg;

    localparam int aluop_w = 8;

    // logic
    localparam logic [aluop_w-1:0] op_nop   = 8'h00;
    localparam logic [aluop_w-1:0] op_or    = 8'h01;
    localparam logic [aluop_w-1:0] op_and   = 8'h02;
    localparam logic [aluop_w-1:0] op_xor   = 8'h03;
    localparam logic [aluop_w-1:0] op_nor   = 8'h04;
    // shift
    localparam logic [aluop_w-1:0] op_sll   = 8'h10;
    localparam logic [aluop_w-1:0] op_srl   = 8'h11;
    localparam logic [aluop_w-1:0] op_sra   = 8'h12;
    // move
    localparam logic [aluop_w-1:0] op_movn  = 8'h20;
    localparam logic [aluop_w-1:0] op_movz  = 8'h21;
    localparam logic [aluop_w-1:0] op_mfhi  = 8'h22;
    localparam logic [aluop_w-1:0] op_mflo  = 8'h23;
    localparam logic [aluop_w-1:0] op_mthi  = 8'h24;
    localparam logic [aluop_w-1:0] op_mtlo  = 8'h25;
    // arithmetic
    localparam logic [aluop_w-1:0] op_add   = 8'h30;
    localparam logic [aluop_w-1:0] op_addu  = 8'h31;
    localparam logic [aluop_w-1:0] op_sub   = 8'h32;
    localparam logic [aluop_w-1:0] op_subu  = 8'h33;
    localparam logic [aluop_w-1:0] op_slt   = 8'h34;
    localparam logic [aluop_w-1:0] op_sltu  = 8'h35;
    localparam logic [aluop_w-1:0] op_clz   = 8'h36;
    localparam logic [aluop_w-1:0] op_clo   = 8'h37;
    localparam logic [aluop_w-1:0] op_mul   = 8'h38;
    // products into hi/lo
    localparam logic [aluop_w-1:0] op_mult  = 8'h40;
    localparam logic [aluop_w-1:0] op_multu = 8'h41;
    localparam logic [aluop_w-1:0] op_madd  = 8'h42;
    localparam logic [aluop_w-1:0] op_maddu = 8'h43;
    localparam logic [aluop_w-1:0] op_msub  = 8'h44;
    localparam logic [aluop_w-1:0] op_msubu = 8'h45;
    localparam logic [aluop_w-1:0] op_div   = 8'h46;
    localparam logic [aluop_w-1:0] op_divu  = 8'h47;
    // load/store
    localparam logic [aluop_w-1:0] op_lw    = 8'h50;
    localparam logic [aluop_w-1:0] op_sw    = 8'h51;

endpackage

// File: div.sv
`timescale 1ns/10ps

module div (
    input  logic                              clk,
    input  logic                              rst_i,
    input  logic                              signed_i,
    input  logic [cpu_defs_pkg::reg_w-1:0]    op1_i,     // dividend
    input  logic [cpu_defs_pkg::reg_w-1:0]    op2_i,     // divisor
    input  logic                              start_i,
    output logic [cpu_defs_pkg::dreg_w-1:0]   result_o,  // {remainder, quotient}
    output logic                              ready_o
);
    localparam int w = cpu_defs_pkg::reg_w;

    typedef enum logic [1:0] {st_idle, st_run, st_done} state_t;

    state_t       state_q;
    logic [4:0]   step_q;
    logic [w-1:0] quo_q;      // dividend shifts out, quotient shifts in
    logic [w-1:0] rem_q;
    logic [w-1:0] den_q;
    logic         neg_quo_q;
    logic         neg_rem_q;
    logic [w:0]   trial;
    logic [w:0]   delta;
    logic [w-1:0] quo_next;
    logic [w-1:0] rem_next;
    logic [w-1:0] mag1;
    logic [w-1:0] mag2;

    assign mag1    = (signed_i && op1_i[w-1]) ? -op1_i : op1_i;
    assign mag2    = (signed_i && op2_i[w-1]) ? -op2_i : op2_i;
    assign ready_o = state_q == st_done;

    // one restoring step
    always_comb begin
        trial = {rem_q, quo_q[w-1]};
        delta = trial - {1'b0, den_q};
        if (delta[w]) begin  // negative, keep partial remainder
            rem_next = trial[w-1:0];
            quo_next = {quo_q[w-2:0], 1'b0};
        end else begin
            rem_next = delta[w-1:0];
            quo_next = {quo_q[w-2:0], 1'b1};
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= st_idle;
            step_q  <= '0;
        end else begin
            case (state_q)
                st_idle: begin
                    step_q <= '0;
                    if (start_i) state_q <= (op2_i == '0) ? st_done : st_run;
                end
                st_run: begin
                    step_q <= step_q + 5'd1;
                    if (!start_i) state_q <= st_idle;  // abandoned
                    else if (step_q == 5'd31) state_q <= st_done;
                end
                default: state_q <= st_idle;  // ready lasts one cycle
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == st_idle && start_i) begin
            quo_q     <= mag1;
            den_q     <= mag2;
            rem_q     <= '0;
            neg_quo_q <= signed_i && (op1_i[w-1] ^ op2_i[w-1]);
            neg_rem_q <= signed_i && op1_i[w-1];  // remainder follows dividend
            result_o  <= '0;                      // stays zero for a zero divisor
        end else if (state_q == st_run) begin
            quo_q <= quo_next;
            rem_q <= rem_next;
            if (step_q == 5'd31) begin
                result_o <= {neg_rem_q ? -rem_next : rem_next,
                             neg_quo_q ? -quo_next : quo_next};
            end
        end
    end

endmodule

// File: hilo_reg.sv
`timescale 1ns/10ps

module hilo_reg (
    input  logic                           clk,
    input  logic                           rst_i,
    input  logic                           hi_we_i,
    input  logic                           lo_we_i,
    input  logic [cpu_defs_pkg::reg_w-1:0] hi_i,
    input  logic [cpu_defs_pkg::reg_w-1:0] lo_i,
    output logic [cpu_defs_pkg::reg_w-1:0] hi_o,
    output logic [cpu_defs_pkg::reg_w-1:0] lo_o
);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            hi_o <= '0;
            lo_o <= '0;
        end else begin
            if (hi_we_i) hi_o <= hi_i;
            if (lo_we_i) lo_o <= lo_i;  // independent of hi
        end
    end

endmodule

// File: ex_mem.sv
`timescale 1ns/10ps

module ex_mem (
    input  logic                                clk,
    input  logic                                rst_i,
    input  logic                                stall_i,
    input  logic [cpu_defs_pkg::reg_addr_w-1:0] waddr_i,
    input  logic                                reg_we_i,
    input  logic [cpu_defs_pkg::reg_w-1:0]      alu_res_i,
    input  logic [alu_op_pkg::aluop_w-1:0]      aluop_i,
    input  logic [cpu_defs_pkg::reg_w-1:0]      reg2_data_i,
    input  logic [1:0]                          cnt_i,
    input  logic [cpu_defs_pkg::dreg_w-1:0]     hilo_temp_i,
    output logic [cpu_defs_pkg::reg_addr_w-1:0] waddr_o,
    output logic                                reg_we_o,
    output logic [cpu_defs_pkg::reg_w-1:0]      alu_res_o,
    output logic [alu_op_pkg::aluop_w-1:0]      aluop_o,
    output logic [cpu_defs_pkg::reg_w-1:0]      reg2_data_o,
    output logic [1:0]                          cnt_o,
    output logic [cpu_defs_pkg::dreg_w-1:0]     hilo_temp_o
);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            waddr_o     <= '0;
            reg_we_o    <= 1'b0;
            alu_res_o   <= '0;
            aluop_o     <= alu_op_pkg::op_nop;
            reg2_data_o <= '0;
            cnt_o       <= 2'd0;
            hilo_temp_o <= '0;
        end else begin
            cnt_o       <= cnt_i;        // advances even while stalled
            hilo_temp_o <= hilo_temp_i;
            if (stall_i) begin
                reg_we_o <= 1'b0;        // bubble, data held
            end else begin
                waddr_o     <= waddr_i;
                reg_we_o    <= reg_we_i;
                alu_res_o   <= alu_res_i;
                aluop_o     <= aluop_i;
                reg2_data_o <= reg2_data_i;
            end
        end
    end

endmodule

// File: ex.sv
`timescale 1ns/10ps

module ex (
    input  logic [cpu_defs_pkg::alusel_w-1:0]    alusel_i,
    input  logic [alu_op_pkg::aluop_w-1:0]       aluop_i,
    input  logic [cpu_defs_pkg::reg_w-1:0]       op1_i,
    input  logic [cpu_defs_pkg::reg_w-1:0]       op2_i,
    input  logic [cpu_defs_pkg::reg_addr_w-1:0]  waddr_i,
    input  logic                                 reg_we_i,
    input  logic [cpu_defs_pkg::reg_w-1:0]       hi_i,
    input  logic [cpu_defs_pkg::reg_w-1:0]       lo_i,
    input  logic [1:0]                           cnt_i,        // accumulate step
    input  logic [cpu_defs_pkg::dreg_w-1:0]      hilo_temp_i,  // product from step 0
    input  logic [cpu_defs_pkg::dreg_w-1:0]      div_result_i,
    input  logic                                 div_ready_i,
    input  logic [cpu_defs_pkg::inst_addr_w-1:0] link_addr_i,
    input  logic [cpu_defs_pkg::reg_w-1:0]       reg2_data_i,  // store data
    output logic [cpu_defs_pkg::reg_addr_w-1:0]  waddr_o,
    output logic                                 reg_we_o,
    output logic [cpu_defs_pkg::reg_w-1:0]       alu_res_o,
    output logic                                 hi_we_o,
    output logic                                 lo_we_o,
    output logic [cpu_defs_pkg::reg_w-1:0]       hi_o,
    output logic [cpu_defs_pkg::reg_w-1:0]       lo_o,
    output logic [1:0]                           cnt_o,
    output logic [cpu_defs_pkg::dreg_w-1:0]      hilo_temp_o,
    output logic                                 div_signed_o,
    output logic [cpu_defs_pkg::reg_w-1:0]       div_op1_o,
    output logic [cpu_defs_pkg::reg_w-1:0]       div_op2_o,
    output logic                                 div_start_o,
    output logic                                 stall_o,
    output logic [alu_op_pkg::aluop_w-1:0]       aluop_o,
    output logic [cpu_defs_pkg::reg_w-1:0]       reg2_data_o
);
    localparam int w = cpu_defs_pkg::reg_w;

    logic [w-1:0] logic_res;
    logic [w-1:0] shift_res;
    logic [w-1:0] move_res;
    logic [w-1:0] arith_res;
    logic [w-1:0] sum;
    logic [w-1:0] diff;
    logic         ovf_add;
    logic         ovf_sub;
    logic [cpu_defs_pkg::dreg_w-1:0] prod_s;
    logic [cpu_defs_pkg::dreg_w-1:0] prod_u;
    logic [cpu_defs_pkg::dreg_w-1:0] acc_data;
    logic         is_acc;
    logic         is_div;
    logic         acc_we;
    logic         acc_stall;

    // count of leading zero bits, 32 for an all-zero word
    function automatic logic [w-1:0] lead_zeros(input logic [w-1:0] word);
        logic [w-1:0] n;
        logic         seen;
        n    = '0;
        seen = 1'b0;
        for (int i = w - 1; i >= 0; i--) begin
            if (word[i]) seen = 1'b1;
            else if (!seen) n = n + 1'b1;
        end
        return n;
    endfunction

    assign sum     = op1_i + op2_i;
    assign diff    = op1_i - op2_i;
    assign ovf_add = (op1_i[w-1] == op2_i[w-1]) && (sum[w-1] != op1_i[w-1]);
    assign ovf_sub = (op1_i[w-1] != op2_i[w-1]) && (diff[w-1] != op1_i[w-1]);
    assign prod_s  = $signed(op1_i) * $signed(op2_i);  // sign-extended to 64
    assign prod_u  = op1_i * op2_i;

    always_comb begin
        logic_res = '0;
        shift_res = '0;
        move_res  = '0;
        arith_res = '0;
        case (aluop_i)
            alu_op_pkg::op_or:    logic_res = op1_i | op2_i;
            alu_op_pkg::op_and:   logic_res = op1_i & op2_i;
            alu_op_pkg::op_xor:   logic_res = op1_i ^ op2_i;
            alu_op_pkg::op_nor:   logic_res = ~(op1_i | op2_i);
            alu_op_pkg::op_sll:   shift_res = op1_i << op2_i[4:0];
            alu_op_pkg::op_srl:   shift_res = op1_i >> op2_i[4:0];
            alu_op_pkg::op_sra:   shift_res = $signed(op1_i) >>> op2_i[4:0];
            alu_op_pkg::op_movn,
            alu_op_pkg::op_movz:  move_res  = op1_i;  // write condition decided in decode
            alu_op_pkg::op_mfhi:  move_res  = hi_i;
            alu_op_pkg::op_mflo:  move_res  = lo_i;
            alu_op_pkg::op_add,
            alu_op_pkg::op_addu:  arith_res = sum;
            alu_op_pkg::op_sub,
            alu_op_pkg::op_subu:  arith_res = diff;
            alu_op_pkg::op_slt:   arith_res = {{(w-1){1'b0}}, $signed(op1_i) < $signed(op2_i)};
            alu_op_pkg::op_sltu:  arith_res = {{(w-1){1'b0}}, op1_i < op2_i};
            alu_op_pkg::op_clz:   arith_res = lead_zeros(op1_i);
            alu_op_pkg::op_clo:   arith_res = lead_zeros(~op1_i);
            alu_op_pkg::op_mul:   arith_res = prod_s[w-1:0];  // low word only
            default: ;
        endcase
    end

    // result select by class
    always_comb begin
        case (alusel_i)
            cpu_defs_pkg::res_logic:       alu_res_o = logic_res;
            cpu_defs_pkg::res_shift:       alu_res_o = shift_res;
            cpu_defs_pkg::res_move:        alu_res_o = move_res;
            cpu_defs_pkg::res_arith:       alu_res_o = arith_res;
            cpu_defs_pkg::res_jump_branch: alu_res_o = link_addr_i;
            cpu_defs_pkg::res_load_store:  alu_res_o = sum;  // effective address
            default:                       alu_res_o = '0;
        endcase
    end

    assign waddr_o     = waddr_i;
    assign reg_we_o    = reg_we_i && !((aluop_i == alu_op_pkg::op_add && ovf_add) ||
                                       (aluop_i == alu_op_pkg::op_sub && ovf_sub));
    assign aluop_o     = aluop_i;
    assign reg2_data_o = reg2_data_i;

    assign is_acc   = aluop_i == alu_op_pkg::op_madd || aluop_i == alu_op_pkg::op_maddu ||
                      aluop_i == alu_op_pkg::op_msub || aluop_i == alu_op_pkg::op_msubu;
    assign acc_data = (aluop_i == alu_op_pkg::op_msub || aluop_i == alu_op_pkg::op_msubu)
                    ? {hi_i, lo_i} - hilo_temp_i : {hi_i, lo_i} + hilo_temp_i;

    // two-step accumulate, cnt fed back through ex_mem
    always_comb begin
        cnt_o       = 2'd0;
        hilo_temp_o = '0;
        acc_we      = 1'b0;
        acc_stall   = 1'b0;
        if (is_acc) begin
            case (cnt_i)
                2'd0: begin
                    hilo_temp_o = (aluop_i == alu_op_pkg::op_madd ||
                                   aluop_i == alu_op_pkg::op_msub) ? prod_s : prod_u;
                    cnt_o       = 2'd1;
                    acc_stall   = 1'b1;
                end
                2'd1: begin
                    cnt_o  = 2'd2;
                    acc_we = 1'b1;
                end
                default: cnt_o = 2'd2;  // done, hold until the instruction leaves
            endcase
        end
    end

    assign is_div       = aluop_i == alu_op_pkg::op_div || aluop_i == alu_op_pkg::op_divu;
    assign div_signed_o = aluop_i == alu_op_pkg::op_div;
    assign div_op1_o    = op1_i;
    assign div_op2_o    = op2_i;
    assign div_start_o  = is_div && !div_ready_i;
    assign stall_o      = acc_stall || (is_div && !div_ready_i);

    // hi/lo write data
    always_comb begin
        hi_we_o = 1'b0;
        lo_we_o = 1'b0;
        hi_o    = '0;
        lo_o    = '0;
        case (aluop_i)
            alu_op_pkg::op_mthi: begin
                hi_we_o = 1'b1;
                hi_o    = op1_i;
            end
            alu_op_pkg::op_mtlo: begin
                lo_we_o = 1'b1;
                lo_o    = op1_i;
            end
            alu_op_pkg::op_mult,
            alu_op_pkg::op_multu: begin
                hi_we_o      = 1'b1;
                lo_we_o      = 1'b1;
                {hi_o, lo_o} = (aluop_i == alu_op_pkg::op_mult) ? prod_s : prod_u;
            end
            alu_op_pkg::op_madd, alu_op_pkg::op_maddu,
            alu_op_pkg::op_msub, alu_op_pkg::op_msubu: begin
                hi_we_o      = acc_we;
                lo_we_o      = acc_we;
                {hi_o, lo_o} = acc_data;
            end
            alu_op_pkg::op_div,
            alu_op_pkg::op_divu: begin
                hi_we_o      = div_ready_i;  // remainder
                lo_we_o      = div_ready_i;  // quotient
                {hi_o, lo_o} = div_result_i;
            end
            default: ;
        endcase
    end

endmodule

// File: exec_unit.sv
`timescale 1ns/10ps

module exec_unit (
    input  logic                                 clk,
    input  logic                                 rst_i,
    input  logic [cpu_defs_pkg::alusel_w-1:0]    alusel_i,
    input  logic [alu_op_pkg::aluop_w-1:0]       aluop_i,
    input  logic [cpu_defs_pkg::reg_w-1:0]       op1_i,
    input  logic [cpu_defs_pkg::reg_w-1:0]       op2_i,
    input  logic [cpu_defs_pkg::reg_addr_w-1:0]  waddr_i,
    input  logic                                 reg_we_i,
    input  logic [cpu_defs_pkg::inst_addr_w-1:0] link_addr_i,
    input  logic [cpu_defs_pkg::reg_w-1:0]       reg2_data_i,
    output logic                                 stall_o,
    output logic [cpu_defs_pkg::reg_addr_w-1:0]  mem_waddr_o,
    output logic                                 mem_reg_we_o,
    output logic [cpu_defs_pkg::reg_w-1:0]       mem_alu_res_o,
    output logic [alu_op_pkg::aluop_w-1:0]       mem_aluop_o,
    output logic [cpu_defs_pkg::reg_w-1:0]       mem_reg2_data_o,
    output logic [cpu_defs_pkg::reg_w-1:0]       hi_o,
    output logic [cpu_defs_pkg::reg_w-1:0]       lo_o
);
    logic [cpu_defs_pkg::reg_addr_w-1:0] ex_waddr;
    logic                                ex_reg_we;
    logic [cpu_defs_pkg::reg_w-1:0]      ex_alu_res;
    logic [alu_op_pkg::aluop_w-1:0]      ex_aluop;
    logic [cpu_defs_pkg::reg_w-1:0]      ex_reg2_data;
    logic                                hi_we;
    logic                                lo_we;
    logic [cpu_defs_pkg::reg_w-1:0]      hi_wdata;
    logic [cpu_defs_pkg::reg_w-1:0]      lo_wdata;
    logic [1:0]                          cnt_ex;      // ex to ex_mem
    logic [1:0]                          cnt_fb;      // ex_mem back to ex
    logic [cpu_defs_pkg::dreg_w-1:0]     hilo_temp_ex;
    logic [cpu_defs_pkg::dreg_w-1:0]     hilo_temp_fb;
    logic                                div_signed;
    logic [cpu_defs_pkg::reg_w-1:0]      div_op1;
    logic [cpu_defs_pkg::reg_w-1:0]      div_op2;
    logic                                div_start;
    logic [cpu_defs_pkg::dreg_w-1:0]     div_result;
    logic                                div_ready;

    ex u_ex (
        .alusel_i(alusel_i), .aluop_i(aluop_i), .op1_i(op1_i), .op2_i(op2_i),
        .waddr_i(waddr_i), .reg_we_i(reg_we_i), .hi_i(hi_o), .lo_i(lo_o),
        .cnt_i(cnt_fb), .hilo_temp_i(hilo_temp_fb),
        .div_result_i(div_result), .div_ready_i(div_ready),
        .link_addr_i(link_addr_i), .reg2_data_i(reg2_data_i),
        .waddr_o(ex_waddr), .reg_we_o(ex_reg_we), .alu_res_o(ex_alu_res),
        .hi_we_o(hi_we), .lo_we_o(lo_we), .hi_o(hi_wdata), .lo_o(lo_wdata),
        .cnt_o(cnt_ex), .hilo_temp_o(hilo_temp_ex),
        .div_signed_o(div_signed), .div_op1_o(div_op1), .div_op2_o(div_op2),
        .div_start_o(div_start), .stall_o(stall_o),
        .aluop_o(ex_aluop), .reg2_data_o(ex_reg2_data)
    );

    div u_div (
        .clk(clk), .rst_i(rst_i), .signed_i(div_signed), .op1_i(div_op1),
        .op2_i(div_op2), .start_i(div_start), .result_o(div_result), .ready_o(div_ready)
    );

    hilo_reg u_hilo_reg (
        .clk(clk), .rst_i(rst_i), .hi_we_i(hi_we), .lo_we_i(lo_we),
        .hi_i(hi_wdata), .lo_i(lo_wdata), .hi_o(hi_o), .lo_o(lo_o)
    );

    ex_mem u_ex_mem (
        .clk(clk), .rst_i(rst_i), .stall_i(stall_o),
        .waddr_i(ex_waddr), .reg_we_i(ex_reg_we), .alu_res_i(ex_alu_res),
        .aluop_i(ex_aluop), .reg2_data_i(ex_reg2_data),
        .cnt_i(cnt_ex), .hilo_temp_i(hilo_temp_ex),
        .waddr_o(mem_waddr_o), .reg_we_o(mem_reg_we_o), .alu_res_o(mem_alu_res_o),
        .aluop_o(mem_aluop_o), .reg2_data_o(mem_reg2_data_o),
        .cnt_o(cnt_fb), .hilo_temp_o(hilo_temp_fb)
    );

endmodule

// File: tb_exec_unit.sv
`timescale 1ns/10ps

module tb_exec_unit;

    localparam int max_tests = 64;
    localparam int rw        = cpu_defs_pkg::reg_w;
    localparam int ow        = alu_op_pkg::aluop_w;
    localparam int aw        = cpu_defs_pkg::reg_addr_w;

    logic                                 clk = 1'b0;
    logic                                 rst_i;
    logic [cpu_defs_pkg::alusel_w-1:0]    alusel_i;
    logic [ow-1:0]                        aluop_i;
    logic [rw-1:0]                        op1_i;
    logic [rw-1:0]                        op2_i;
    logic [aw-1:0]                        waddr_i;
    logic                                 reg_we_i;
    logic [cpu_defs_pkg::inst_addr_w-1:0] link_addr_i;
    logic [rw-1:0]                        reg2_data_i;
    logic                                 stall_o;
    logic [aw-1:0]                        mem_waddr_o;
    logic                                 mem_reg_we_o;
    logic [rw-1:0]                        mem_alu_res_o;
    logic [ow-1:0]                        mem_aluop_o;
    logic [rw-1:0]                        mem_reg2_data_o;
    logic [rw-1:0]                        hi_o;
    logic [rw-1:0]                        lo_o;

    // op sel op1 op2 waddr we link reg2 res res_we hi lo per golden row
    logic [31:0] vec [max_tests][12];
    int          n_tests     = 0;
    int          cycles      = 0;
    int          cycle_limit = 0;
    int          test_errors = 0;
    int          passed      = 0;
    int          failed      = 0;

    exec_unit uut (
        .clk(clk), .rst_i(rst_i), .alusel_i(alusel_i), .aluop_i(aluop_i),
        .op1_i(op1_i), .op2_i(op2_i), .waddr_i(waddr_i), .reg_we_i(reg_we_i),
        .link_addr_i(link_addr_i), .reg2_data_i(reg2_data_i), .stall_o(stall_o),
        .mem_waddr_o(mem_waddr_o), .mem_reg_we_o(mem_reg_we_o),
        .mem_alu_res_o(mem_alu_res_o), .mem_aluop_o(mem_aluop_o),
        .mem_reg2_data_o(mem_reg2_data_o), .hi_o(hi_o), .lo_o(lo_o)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("run timed out after %0d cycles waiting for stall_o to fall", cycles);
            $display("TB FAILED");
            $finish;
        end
    end

    task automatic load_vectors;
        int    fd;
        string line;
        fd = $fopen("exec_golden.txt", "r");
        if (fd == 0) return;
        while ($fgets(line, fd) != 0 && n_tests < max_tests) begin
            if (line.len() > 1 && line.getc(0) != "#") begin  // skip comments and blanks
                if ($sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h",
                            vec[n_tests][0], vec[n_tests][1], vec[n_tests][2],
                            vec[n_tests][3], vec[n_tests][4], vec[n_tests][5],
                            vec[n_tests][6], vec[n_tests][7], vec[n_tests][8],
                            vec[n_tests][9], vec[n_tests][10], vec[n_tests][11]) == 12)
                    n_tests++;
            end
        end
        $fclose(fd);
    endtask

    // an accumulate stalls once and a divide for setup plus one cycle per quotient bit
    function automatic int stall_cycles(input logic [ow-1:0] op, input logic [rw-1:0] divisor);
        if (op == alu_op_pkg::op_madd || op == alu_op_pkg::op_maddu ||
            op == alu_op_pkg::op_msub || op == alu_op_pkg::op_msubu)
            return 1;
        else if (op == alu_op_pkg::op_div || op == alu_op_pkg::op_divu)
            return (divisor == '0) ? 1 : 33;
        else
            return 0;
    endfunction

    task automatic apply_vector(input int i);
        aluop_i     <= vec[i][0][ow-1:0];
        alusel_i    <= vec[i][1][cpu_defs_pkg::alusel_w-1:0];
        op1_i       <= vec[i][2];
        op2_i       <= vec[i][3];
        waddr_i     <= vec[i][4][aw-1:0];
        reg_we_i    <= vec[i][5][0];
        link_addr_i <= vec[i][6];
        reg2_data_i <= vec[i][7];
    endtask

    task automatic insert_bubble;
        aluop_i     <= alu_op_pkg::op_nop;
        alusel_i    <= cpu_defs_pkg::res_nop;
        op1_i       <= '0;
        op2_i       <= '0;
        waddr_i     <= '0;
        reg_we_i    <= 1'b0;
        link_addr_i <= '0;
        reg2_data_i <= '0;
    endtask

    task automatic check_word(input string name, input logic [rw-1:0] exp,
                              input logic [rw-1:0] act);
        if (act !== exp) begin
            $display("Fail at %0t: %s expected %h, got %h", $time, name, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Fail at %0t: %s expected %b, got %b", $time, name, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_addr(input string name, input logic [aw-1:0] exp,
                              input logic [aw-1:0] act);
        if (act !== exp) begin
            $display("Fail at %0t: %s expected %h, got %h", $time, name, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_op(input string name, input logic [ow-1:0] exp,
                            input logic [ow-1:0] act);
        if (act !== exp) begin
            $display("Fail at %0t: %s expected %h, got %h", $time, name, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("Fail at %0t: %s expected %0d, got %0d", $time, name, exp, act);
            test_errors++;
        end
    endtask

    task automatic run_test(input int i);
        int stalls;
        stalls      = 0;
        test_errors = 0;
        @(posedge clk);
        apply_vector(i);
        @(negedge clk);
        while (stall_o) begin
            stalls++;
            check_bit("mem_reg_we_o", 1'b0, mem_reg_we_o);  // empty slot while stalled
            check_op("mem_aluop_o", alu_op_pkg::op_nop, mem_aluop_o);  // bubble held
            @(negedge clk);
        end
        @(posedge clk);  // instruction leaves ex here
        insert_bubble();
        @(negedge clk);
        check_count("stall cycles", stall_cycles(vec[i][0][ow-1:0], vec[i][3]), stalls);
        check_word("mem_alu_res_o", vec[i][8], mem_alu_res_o);
        check_bit("mem_reg_we_o", vec[i][9][0], mem_reg_we_o);
        check_addr("mem_waddr_o", vec[i][4][aw-1:0], mem_waddr_o);
        check_op("mem_aluop_o", vec[i][0][ow-1:0], mem_aluop_o);
        check_word("mem_reg2_data_o", vec[i][7], mem_reg2_data_o);
        check_word("hi_o", vec[i][10], hi_o);
        check_word("lo_o", vec[i][11], lo_o);
        if (test_errors == 0) passed++;
        else failed++;
        $display("test %0d op %h: %0d errors", i, vec[i][0][ow-1:0], test_errors);
    endtask

    initial begin
        rst_i       = 1'b1;
        aluop_i     = alu_op_pkg::op_nop;
        alusel_i    = cpu_defs_pkg::res_nop;
        op1_i       = '0;
        op2_i       = '0;
        waddr_i     = '0;
        reg_we_i    = 1'b0;
        link_addr_i = '0;
        reg2_data_i = '0;
        load_vectors();
        cycle_limit = 40 * n_tests + 20;  // a divide needs about 36 cycles
        if (n_tests == 0) begin
            $display("no vectors could be read from exec_golden.txt");
            $display("TB FAILED");
            $finish;
        end else begin
            repeat (5) @(posedge clk);
            rst_i <= 1'b0;
            for (int i = 0; i < n_tests; i++) run_test(i);
            $display("%0d tests passed, %0d failed", passed, failed);
            if (failed == 0) begin
                $display("TB PASSED");
            end else begin
                $display("TB FAILED");
            end
            $finish;
        end
    end

endmodule

// File: exec_golden.txt
# op sel op1 op2 waddr we link reg2 then expected result, write enable, hi, lo (hex)
# hi and lo give the register state after the row, rows run in order
01 1 f0f00000 00ff00ff 03 1 00000000 00000000 f0ff00ff 1 00000000 00000000
02 1 f0f0f0f0 ff00ff00 04 1 00000000 00000000 f000f000 1 00000000 00000000
03 1 aaaa5555 ffff0000 05 1 00000000 00000000 55555555 1 00000000 00000000
04 1 0f0f0f0f 00000000 06 1 00000000 00000000 f0f0f0f0 1 00000000 00000000
10 2 00000001 0000001f 07 1 00000000 00000000 80000000 1 00000000 00000000
11 2 80000000 00000004 08 1 00000000 00000000 08000000 1 00000000 00000000
12 2 80000000 00000004 09 1 00000000 00000000 f8000000 1 00000000 00000000
34 4 ffffffff 00000001 0a 1 00000000 00000000 00000001 1 00000000 00000000
35 4 ffffffff 00000001 0b 1 00000000 00000000 00000000 1 00000000 00000000
36 4 00000000 00000000 0c 1 00000000 00000000 00000020 1 00000000 00000000
36 4 00010000 00000000 0c 1 00000000 00000000 0000000f 1 00000000 00000000
37 4 fff00000 00000000 0c 1 00000000 00000000 0000000c 1 00000000 00000000
30 4 7fffffff 00000001 0d 1 00000000 00000000 80000000 0 00000000 00000000
31 4 7fffffff 00000001 0e 1 00000000 00000000 80000000 1 00000000 00000000
32 4 00000005 00000007 0f 1 00000000 00000000 fffffffe 1 00000000 00000000
32 4 80000000 00000001 0f 1 00000000 00000000 7fffffff 0 00000000 00000000
38 4 fffffffd 00000004 10 1 00000000 00000000 fffffff4 1 00000000 00000000
24 0 12345678 00000000 00 0 00000000 00000000 00000000 0 12345678 00000000
25 0 9abcdef0 00000000 00 0 00000000 00000000 00000000 0 12345678 9abcdef0
22 3 00000000 00000000 10 1 00000000 00000000 12345678 1 12345678 9abcdef0
23 3 00000000 00000000 11 1 00000000 00000000 9abcdef0 1 12345678 9abcdef0
40 0 fffffffe 00000003 00 0 00000000 00000000 00000000 0 ffffffff fffffffa
41 0 fffffffe 00000003 00 0 00000000 00000000 00000000 0 00000002 fffffffa
40 0 00010000 00010000 00 0 00000000 00000000 00000000 0 00000001 00000000
42 0 00000003 00000005 00 0 00000000 00000000 00000000 0 00000001 0000000f
44 0 00000002 00000010 00 0 00000000 00000000 00000000 0 00000000 ffffffef
43 0 ffffffff 00000002 00 0 00000000 00000000 00000000 0 00000002 ffffffed
44 0 ffffffff 00000001 00 0 00000000 00000000 00000000 0 00000002 ffffffee
46 0 fffffff9 00000002 00 0 00000000 00000000 00000000 0 ffffffff fffffffd
46 0 00000007 fffffffe 00 0 00000000 00000000 00000000 0 00000001 fffffffd
47 0 fffffff9 00000002 00 0 00000000 00000000 00000000 0 00000001 7ffffffc
46 0 00000064 00000000 00 0 00000000 00000000 00000000 0 00000000 00000000
50 6 00001000 00000024 11 1 00000000 00000000 00001024 1 00000000 00000000
51 6 00002000 fffffffc 00 0 00000000 cafef00d 00001ffc 0 00000000 00000000
00 5 00000000 00000000 1f 1 00400008 00000000 00400008 1 00000000 00000000
00 0 12345678 00000009 00 0 00000000 00000000 00000000 0 00000000 00000000

// File: src.f
cpu_defs_pkg.sv
alu_op_pkg.sv
div.sv
hilo_reg.sv
ex_mem.sv
ex.sv
exec_unit.sv
tb_exec_unit.sv

// File: Makefile
TOP = tb_exec_unit

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f src.f -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TB PASSED"

clean:
	rm -rf obj_dir
